// ==== rtl/tcb_bus_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// TCB lite bus constants, logarithmic size mode only (no byte enables)
// data is little-endian and LSB-justified, lock signal is not carried
////////////////////////////////////////////////////////////////////////////

package tcb_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////////////////////

    // byte address width
    localparam int unsigned bus_aw = 16;

    // data width, a whole number of bytes
    localparam int unsigned bus_dw = 32;

    // number of byte lanes
    localparam int unsigned bus_bw = bus_dw / 8;

    ////////////////////////////////////////////////////////////////////////////
    // size encoding
    ////////////////////////////////////////////////////////////////////////////

    // transfer size is 2**siz bytes
    // 0 -> byte, 1 -> half word, 2 -> word
    // 3 would be a double word, which does not fit this bus and is an error
    localparam int unsigned bus_sw = 2;

    ////////////////////////////////////////////////////////////////////////////
    // response timing
    ////////////////////////////////////////////////////////////////////////////

    // cycles from the subordinate-side transfer to rdt/err
    localparam int unsigned bus_delay = 1;

endpackage : tcb_bus_pkg

// ==== rtl/tcb_mem_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// SRAM geometry, the array is organized in bus-wide words
////////////////////////////////////////////////////////////////////////////

package tcb_mem_pkg;

    // total SRAM capacity in bytes
    // addresses at or above this value are reported as errors
    localparam int unsigned mem_bytes = 1024;

    // number of bus-wide words in the array
    localparam int unsigned mem_words = mem_bytes / tcb_bus_pkg::bus_bw;

    // width of the word index, taken from the address above the byte offset
    localparam int unsigned mem_iw = $clog2(mem_words);

endpackage : tcb_mem_pkg

// ==== rtl/tcb_mem_array.sv ====
////////////////////////////////////////////////////////////////////////////
// word storage with byte write enables and one cycle read latency
// contents are unknown after power-up, write before reading
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_mem_array (
    input  logic                            sub,
    input  logic                            ren,
    input  logic [tcb_mem_pkg::mem_iw-1:0]  idx,
    input  logic [tcb_bus_pkg::bus_bw-1:0]  ben,
    input  logic [tcb_bus_pkg::bus_dw-1:0]  wdt,
    output logic [tcb_bus_pkg::bus_dw-1:0]  rdt
);

    import tcb_bus_pkg::*;
    import tcb_mem_pkg::*;

    // one entry per bus word
    logic [bus_dw-1:0] mem [mem_words];

    ////////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////////

    // each enabled lane is stored at the edge, others keep their byte
    always_ff @(posedge sub) begin
        for (int unsigned i = 0; i < bus_bw; i++) begin
            if (ben[i]) begin
                mem[idx][8*i +: 8] <= wdt[8*i +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////////////////////

    // output register holds the last read word between reads
    always_ff @(posedge sub) begin
        if (ren) begin
            rdt <= mem[idx];
        end
    end

endmodule : tcb_mem_array

// ==== rtl/tcb_mem_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// SRAM subordinate, ready drops for one cycle after every write transfer
// read data comes from a registered array, so the response needs bus_delay 1
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_mem_ctrl (
    input  logic                            sub,
    input  logic                            rst_n,
    // request
    input  logic                            vld,
    input  logic                            wen,
    input  logic [tcb_bus_pkg::bus_aw-1:0]  adr,
    input  logic [tcb_bus_pkg::bus_sw-1:0]  siz,
    input  logic [tcb_bus_pkg::bus_dw-1:0]  wdt,
    // response
    output logic                            rdy,
    output logic [tcb_bus_pkg::bus_dw-1:0]  rdt,
    output logic                            err
);

    import tcb_bus_pkg::*;
    import tcb_mem_pkg::*;

    // width of the byte offset inside a word
    localparam int unsigned ow = $clog2(bus_bw);

    logic                   trn;
    logic [mem_iw-1:0]      idx;
    logic [ow-1:0]          off;
    logic [ow-1:0]          aln_msk;
    logic [bus_bw-1:0]      lane;
    logic                   err_siz;
    logic                   err_aln;
    logic                   err_rng;
    logic                   req_err;
    logic [bus_bw-1:0]      ben;
    logic [bus_dw-1:0]      mem_wdt;
    logic                   ren;
    logic [bus_dw-1:0]      mem_rdt;
    logic                   wrc;
    logic [bus_delay-1:0]   dly_vld;
    logic [bus_delay-1:0]   dly_ren;
    logic [bus_delay-1:0]   dly_err;
    logic [ow-1:0]          dly_off [bus_delay];
    logic [bus_sw-1:0]      dly_siz [bus_delay];
    logic [bus_dw-1:0]      rsp_sft;
    logic [bus_bw-1:0]      rsp_lane;

    ////////////////////////////////////////////////////////////////////////////
    // request decode
    ////////////////////////////////////////////////////////////////////////////

    assign trn = vld & rdy;

    // word index above the offset, upper address bits only matter for range
    assign idx = adr[ow +: mem_iw];
    assign off = adr[ow-1:0];

    // low offset bits that must be zero for an aligned transfer
    assign aln_msk = ow'((1 << siz) - 1);

    // lanes used by an LSB-justified transfer of 2**siz bytes
    always_comb begin
        for (int unsigned i = 0; i < bus_bw; i++) begin
            lane[i] = (i < (1 << siz));
        end
    end

    // wider than the bus, misaligned, or past the end of the SRAM
    assign err_siz = (siz > ow);
    assign err_aln = |(off & aln_msk);
    assign err_rng = (adr >= mem_bytes);
    assign req_err = err_siz | err_aln | err_rng;

    ////////////////////////////////////////////////////////////////////////////
    // array access
    ////////////////////////////////////////////////////////////////////////////

    // move write bytes from lane 0 up to the addressed lanes
    assign mem_wdt = wdt << {off, 3'b000};

    // byte enables only for legal writes, nothing is stored on error
    assign ben = (trn && wen && !req_err) ? (lane << off) : '0;

    // illegal reads leave the array alone
    assign ren = trn & ~wen & ~req_err;

    tcb_mem_array tcb_mem_array_i (
        .sub (sub),
        .ren (ren),
        .idx (idx),
        .ben (ben),
        .wdt (mem_wdt),
        .rdt (mem_rdt)
    );

    ////////////////////////////////////////////////////////////////////////////
    // write recovery
    ////////////////////////////////////////////////////////////////////////////

    // one idle cycle after each accepted write, errored writes included
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            wrc <= 1'b0;
        end else begin
            wrc <= trn & wen;
        end
    end

    assign rdy = ~wrc;

    ////////////////////////////////////////////////////////////////////////////
    // response delay stage
    ////////////////////////////////////////////////////////////////////////////

    // response valid, shifted once per cycle
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            dly_vld <= '0;
        end else begin
            dly_vld[0] <= trn;
            for (int unsigned i = 1; i < bus_delay; i++) begin
                dly_vld[i] <= dly_vld[i-1];
            end
        end
    end

    // transfer attributes needed to shape the response
    always_ff @(posedge sub) begin
        dly_ren[0] <= ren;
        dly_err[0] <= req_err;
        dly_off[0] <= off;
        dly_siz[0] <= siz;
        for (int unsigned i = 1; i < bus_delay; i++) begin
            dly_ren[i] <= dly_ren[i-1];
            dly_err[i] <= dly_err[i-1];
            dly_off[i] <= dly_off[i-1];
            dly_siz[i] <= dly_siz[i-1];
        end
    end

    // bring the addressed bytes down to lane 0
    assign rsp_sft = mem_rdt >> {dly_off[bus_delay-1], 3'b000};

    always_comb begin
        for (int unsigned i = 0; i < bus_bw; i++) begin
            rsp_lane[i] = (i < (1 << dly_siz[bus_delay-1]));
        end
    end

    // upper lanes zero, whole word zero for writes and errors
    always_comb begin
        for (int unsigned i = 0; i < bus_bw; i++) begin
            if (dly_ren[bus_delay-1] && rsp_lane[i]) begin
                rdt[8*i +: 8] = rsp_sft[8*i +: 8];
            end else begin
                rdt[8*i +: 8] = 8'h00;
            end
        end
    end

    assign err = dly_vld[bus_delay-1] & dly_err[bus_delay-1];

endmodule : tcb_mem_ctrl

// ==== rtl/tcb_req_slice.sv ====
////////////////////////////////////////////////////////////////////////////
// request path register slice, response signals pass through unregistered
// adds one cycle of request latency and no bubbles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_req_slice (
    input  logic                            sub,
    input  logic                            rst_n,
    // manager side request, enters the slice here
    input  logic                            sub_vld,
    input  logic                            sub_wen,
    input  logic [tcb_bus_pkg::bus_aw-1:0]  sub_adr,
    input  logic [tcb_bus_pkg::bus_sw-1:0]  sub_siz,
    input  logic [tcb_bus_pkg::bus_dw-1:0]  sub_wdt,
    output logic                            sub_rdy,
    output logic [tcb_bus_pkg::bus_dw-1:0]  sub_rdt,
    output logic                            sub_err,
    // registered request towards the subordinate
    output logic                            man_vld,
    output logic                            man_wen,
    output logic [tcb_bus_pkg::bus_aw-1:0]  man_adr,
    output logic [tcb_bus_pkg::bus_sw-1:0]  man_siz,
    output logic [tcb_bus_pkg::bus_dw-1:0]  man_wdt,
    input  logic                            man_rdy,
    input  logic [tcb_bus_pkg::bus_dw-1:0]  man_rdt,
    input  logic                            man_err
);

    import tcb_bus_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////////////////////

    // the output stage can take a new request when it is empty
    // or when its current request is being taken this cycle
    assign sub_rdy = man_rdy | ~man_vld;

    // valid follows the input whenever the stage is open
    // while stalled the stored request stays valid
    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            man_vld <= 1'b0;
        end else if (sub_rdy) begin
            man_vld <= sub_vld;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // request payload
    ////////////////////////////////////////////////////////////////////////////

    // control fields, qualified by man_vld downstream
    always_ff @(posedge sub) begin
        if (sub_rdy) begin
            man_wen <= sub_wen;
            man_adr <= sub_adr;
            man_siz <= sub_siz;
        end
    end

    // write data, only the lanes that carry the LSB-justified transfer
    // unused lanes keep stale bytes, the subordinate masks them anyway
    always_ff @(posedge sub) begin
        if (sub_rdy && sub_wen) begin
            for (int unsigned i = 0; i < bus_bw; i++) begin
                if (i < (1 << sub_siz)) begin
                    man_wdt[8*i +: 8] <= sub_wdt[8*i +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////////////////////

    // same cycle as the subordinate drives them
    assign sub_rdt = man_rdt;
    assign sub_err = man_err;

endmodule : tcb_req_slice

// ==== rtl/tcb_sram_sys.sv ====
////////////////////////////////////////////////////////////////////////////
// request slice in front of the SRAM subordinate
// responses arrive 2 cycles after a top transfer plus any stall cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_sram_sys (
    input  logic                            sub,
    input  logic                            rst_n,
    // manager facing TCB port
    input  logic                            sub_vld,
    input  logic                            sub_wen,
    input  logic [tcb_bus_pkg::bus_aw-1:0]  sub_adr,
    input  logic [tcb_bus_pkg::bus_sw-1:0]  sub_siz,
    input  logic [tcb_bus_pkg::bus_dw-1:0]  sub_wdt,
    output logic                            sub_rdy,
    output logic [tcb_bus_pkg::bus_dw-1:0]  sub_rdt,
    output logic                            sub_err
);

    import tcb_bus_pkg::*;

    // slice to memory request
    logic              man_vld;
    logic              man_wen;
    logic [bus_aw-1:0] man_adr;
    logic [bus_sw-1:0] man_siz;
    logic [bus_dw-1:0] man_wdt;

    // memory to slice response
    logic              man_rdy;
    logic [bus_dw-1:0] man_rdt;
    logic              man_err;

    ////////////////////////////////////////////////////////////////////////////
    // request register slice
    ////////////////////////////////////////////////////////////////////////////

    tcb_req_slice tcb_req_slice_i (
        .sub     (sub),
        .rst_n   (rst_n),
        .sub_vld (sub_vld),
        .sub_wen (sub_wen),
        .sub_adr (sub_adr),
        .sub_siz (sub_siz),
        .sub_wdt (sub_wdt),
        .sub_rdy (sub_rdy),
        .sub_rdt (sub_rdt),
        .sub_err (sub_err),
        .man_vld (man_vld),
        .man_wen (man_wen),
        .man_adr (man_adr),
        .man_siz (man_siz),
        .man_wdt (man_wdt),
        .man_rdy (man_rdy),
        .man_rdt (man_rdt),
        .man_err (man_err)
    );

    ////////////////////////////////////////////////////////////////////////////
    // SRAM subordinate
    ////////////////////////////////////////////////////////////////////////////

    tcb_mem_ctrl tcb_mem_ctrl_i (
        .sub   (sub),
        .rst_n (rst_n),
        .vld   (man_vld),
        .wen   (man_wen),
        .adr   (man_adr),
        .siz   (man_siz),
        .wdt   (man_wdt),
        .rdy   (man_rdy),
        .rdt   (man_rdt),
        .err   (man_err)
    );

endmodule : tcb_sram_sys

// ==== test/tcb_clk_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench clock with 8 ns period, reset held low for the first 8 cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_clk_gen (
    output logic sub,
    output logic rst_n
);

    // half of the 8 ns period
    localparam realtime half_period = 4.0;

    // cycles with reset asserted
    localparam int unsigned rst_cycles = 8;

    initial begin
        sub = 1'b0;
        forever begin
            #(half_period) sub = ~sub;
        end
    end

    // released on a falling edge, well away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(negedge sub);
        rst_n = 1'b1;
    end

endmodule : tcb_clk_gen

// ==== test/tcb_sram_sys_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// random transfers checked against a byte image and a cycle model
// the model assumes bus_delay 1, each test drains before the next starts
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tcb_sram_sys_tb;

    import tcb_bus_pkg::*;
    import tcb_mem_pkg::*;

    typedef struct packed {
        logic              wen;
        logic [bus_aw-1:0] adr;
        logic [bus_sw-1:0] siz;
        logic [bus_dw-1:0] wdt;
        logic [1:0]        gap;
    } req_t;

    // transfers per test, the watchdog is sized from their sum
    localparam int unsigned n_round   = 2 * mem_words;
    localparam int unsigned n_sub     = 3 * 100;
    localparam int unsigned n_err     = 2 * 40;
    localparam int unsigned n_bp      = 64;
    localparam int unsigned n_thr     = 64;
    localparam int unsigned n_mix     = 2000;
    localparam int unsigned n_total   = n_round + n_sub + n_err + n_bp + n_thr + n_mix;
    localparam int unsigned wd_cycles = 4 * n_total + 8 + 200;

    logic              sub;
    logic              rst_n;
    logic              sub_vld;
    logic              sub_wen;
    logic [bus_aw-1:0] sub_adr;
    logic [bus_sw-1:0] sub_siz;
    logic [bus_dw-1:0] sub_wdt;
    logic              sub_rdy;
    logic [bus_dw-1:0] sub_rdt;
    logic              sub_err;

    req_t              req_q [$];
    logic [7:0]        image [mem_bytes];
    int                tests;
    int                checks;
    int                errors;

    // man_vld, the stored request and the write recovery flag
    bit                m_vld;
    bit                m_wrc;
    req_t              m_req;

    // response due in the current cycle, rdt only compared for reads and errors
    bit                r_vld;
    bit                r_chk;
    bit                r_err;
    logic [bus_dw-1:0] r_rdt;

    tcb_clk_gen tcb_clk_gen_i (
        .sub   (sub),
        .rst_n (rst_n)
    );

    tcb_sram_sys tcb_sram_sys_i (
        .sub     (sub),
        .rst_n   (rst_n),
        .sub_vld (sub_vld),
        .sub_wen (sub_wen),
        .sub_adr (sub_adr),
        .sub_siz (sub_siz),
        .sub_wdt (sub_wdt),
        .sub_rdy (sub_rdy),
        .sub_rdt (sub_rdt),
        .sub_err (sub_err)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic req_t make_req(bit wen, int unsigned adr, int unsigned siz,
                                      int unsigned gap);
        req_t r;
        r.wen = wen;
        r.adr = adr[bus_aw-1:0];
        r.siz = siz[bus_sw-1:0];
        r.wdt = $urandom();
        r.gap = gap[1:0];
        return r;
    endfunction

    // size, alignment and range rules, LSB-justified lanes, image updated on writes
    function automatic void access_image(input req_t r, output bit e,
                                         output logic [bus_dw-1:0] d);
        int unsigned n;
        n = 1 << r.siz;
        e = (r.siz == 3) || ((r.adr % n) != 0) || (r.adr >= mem_bytes);
        d = '0;
        if (!e) begin
            for (int unsigned i = 0; i < n; i++) begin
                if (r.wen) begin
                    image[r.adr + i] = r.wdt[8*i +: 8];
                end else begin
                    d[8*i +: 8] = image[r.adr + i];
                end
            end
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // cycle loop, checks on the falling edge, then drives and steps the model
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_test(input string name, input bit thr_chk);
        int   idx;
        int   wait_cnt;
        int   issued;
        int   fails;
        bit   pres;
        bit   exp_rdy;
        bit   mem_trn;
        req_t cur;
        idx = 0;
        wait_cnt = 0;
        issued = 0;
        fails = 0;
        pres = 1'b0;
        cur = '0;
        while (idx < req_q.size() || pres || m_vld || r_vld) begin
            @(negedge sub);
            // outputs come from registers, stable here
            exp_rdy = ~m_wrc | ~m_vld;
            checks++;
            assert (sub_rdy === exp_rdy) else begin
                $display("mismatch %s: sub_rdy expected %0b actual %0b", name, exp_rdy, sub_rdy);
                fails++;
            end
            if (r_vld) begin
                checks++;
                assert (sub_err === r_err) else begin
                    $display("mismatch %s: sub_err expected %0b actual %0b", name, r_err, sub_err);
                    fails++;
                end
                if (r_chk) begin
                    checks++;
                    assert (sub_rdt === r_rdt) else begin
                        $display("mismatch %s: sub_rdt expected %08h actual %08h",
                                 name, r_rdt, sub_rdt);
                        fails++;
                    end
                end
            end else begin
                checks++;
                assert (sub_err === 1'b0) else begin
                    $display("%s: sub_err is high in a cycle with no response", name);
                    fails++;
                end
            end
            // next request once its gap has passed
            if (!pres && idx < req_q.size()) begin
                if (wait_cnt < req_q[idx].gap) begin
                    wait_cnt++;
                end else begin
                    cur = req_q[idx];
                    idx++;
                    wait_cnt = 0;
                    pres = 1'b1;
                end
            end
            sub_vld = pres;
            sub_wen = cur.wen;
            sub_adr = cur.adr;
            sub_siz = cur.siz;
            sub_wdt = cur.wdt;
            // a pure read stream is taken every cycle
            if (thr_chk && pres) begin
                checks++;
                assert (sub_rdy === 1'b1) else begin
                    $display("%s: read held off in a stream that needs no stall", name);
                    fails++;
                end
            end
            // transfers the DUT itself takes at the coming edge
            if (pres && sub_rdy === 1'b1) begin
                issued++;
            end
            // memory side first, it uses the request stored before this edge
            mem_trn = m_vld & ~m_wrc;
            r_vld = mem_trn;
            if (mem_trn) begin
                access_image(m_req, r_err, r_rdt);
                r_chk = ~m_req.wen | r_err;
            end
            m_wrc = mem_trn & m_req.wen;
            // slice loads whenever its ready is high
            if (exp_rdy) begin
                m_vld = pres;
                m_req = cur;
            end
            if (pres && exp_rdy) begin
                pres = 1'b0;
            end
        end
        checks++;
        assert (issued == req_q.size()) else begin
            $display("%s: DUT accepted %0d of %0d transfers", name, issued, req_q.size());
            fails++;
        end
        $display("test %s: %0d transfers, %0d errors", name, issued, fails);
        errors += fails;
        tests++;
        req_q.delete();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_round_trip();
        for (int unsigned w = 0; w < mem_words; w++) begin
            req_q.push_back(make_req(1'b1, bus_bw * w, 2, 0));
        end
        for (int unsigned w = 0; w < mem_words; w++) begin
            req_q.push_back(make_req(1'b0, bus_bw * w, 2, 0));
        end
    endtask

    task automatic build_sub_word();
        int unsigned siz;
        int unsigned adr;
        repeat (n_sub / 3) begin
            siz = $urandom_range(1, 0);
            adr = $urandom_range(mem_bytes - 1, 0) & ~((1 << siz) - 1);
            req_q.push_back(make_req(1'b1, adr, siz, 0));
            req_q.push_back(make_req(1'b0, adr, siz, 0));
            // whole word, shows the neighbor bytes
            req_q.push_back(make_req(1'b0, adr & ~(bus_bw - 1), 2, 0));
        end
    endtask

    task automatic build_errors();
        int unsigned kind;
        int unsigned siz;
        int unsigned adr;
        repeat (n_err / 2) begin
            kind = $urandom_range(2, 0);
            siz = $urandom_range(2, 1);
            adr = $urandom_range(mem_bytes - 1, 0) & ~((1 << siz) - 1);
            case (kind)
                0: adr = adr + $urandom_range((1 << siz) - 1, 1);
                1: siz = 3;
                default: adr = adr + mem_bytes * $urandom_range(63, 1);
            endcase
            req_q.push_back(make_req($urandom_range(1, 0) == 1, adr, siz, 0));
            // aliased word must be unchanged
            req_q.push_back(make_req(1'b0, (adr % mem_bytes) & ~(bus_bw - 1), 2, 1));
        end
    endtask

    task automatic build_stream(input int unsigned n, input int unsigned wr_pct);
        repeat (n) begin
            req_q.push_back(make_req($urandom_range(99, 0) < wr_pct,
                                     bus_bw * $urandom_range(mem_words - 1, 0), 2, 0));
        end
    endtask

    task automatic build_random_mix();
        int unsigned siz;
        int unsigned adr;
        int unsigned gap;
        repeat (n_mix) begin
            siz = ($urandom_range(15, 0) == 0) ? 3 : $urandom_range(2, 0);
            adr = $urandom_range(mem_bytes - 1, 0);
            // mostly aligned, a few misaligned or past the SRAM
            if ($urandom_range(7, 0) != 0) begin
                adr = adr & ~((1 << siz) - 1);
            end
            if ($urandom_range(15, 0) == 0) begin
                adr = adr + mem_bytes;
            end
            gap = ($urandom_range(3, 0) == 0) ? $urandom_range(2, 1) : 0;
            req_q.push_back(make_req($urandom_range(1, 0) == 1, adr, siz, gap));
        end
    endtask

    initial begin
        void'($urandom(32'hc13d_72f9));
        sub_vld = 1'b0;
        sub_wen = 1'b0;
        sub_adr = '0;
        sub_siz = '0;
        sub_wdt = '0;
        tests = 0;
        checks = 0;
        errors = 0;
        m_vld = 1'b0;
        m_wrc = 1'b0;
        r_vld = 1'b0;
        wait (rst_n === 1'b1);
        build_round_trip();
        run_test("round_trip", 1'b0);
        build_sub_word();
        run_test("sub_word", 1'b0);
        build_errors();
        run_test("errors", 1'b0);
        // mostly writes, so write recovery stalls the full slice
        build_stream(n_bp, 75);
        run_test("back_pressure", 1'b0);
        build_stream(n_thr, 0);
        run_test("throughput", 1'b1);
        build_random_mix();
        run_test("random_mix", 1'b0);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // worst case 4 cycles per transfer plus reset and drain
    initial begin
        repeat (wd_cycles) @(posedge sub);
        $display("watchdog: run did not finish within %0d cycles", wd_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule : tcb_sram_sys_tb

// ==== tcb_sram_sys.f ====
rtl/tcb_bus_pkg.sv
rtl/tcb_mem_pkg.sv
rtl/tcb_mem_array.sv
rtl/tcb_mem_ctrl.sv
rtl/tcb_req_slice.sv
rtl/tcb_sram_sys.sv
test/tcb_clk_gen.sv
test/tcb_sram_sys_tb.sv
